//--- source/videoTypesPkg.sv
//####################
// Video data types
// Pixel colour, palette numbers, line buffer
// columns and words, output palette address
//####################

package videoTypesPkg;

	// Colour index inside one palette, zero is transparent
	typedef logic [3:0] colorIndex;

	// Sprite palette number
	typedef logic [7:0] spritePalette;

	// Fix layer palette number
	typedef logic [3:0] fixPalette;

	// Line buffer column
	typedef logic [7:0] lbAddr;

	// Buffer word, sprite palette above colour
	typedef logic [11:0] lbEntry;

	// Palette RAM address on the output bus
	typedef logic [11:0] paletteAddr;

	// Cleared entry, reads back as palette address FFF
	localparam lbEntry backdropCode = '1;

endpackage

//--- source/lineControlPkg.sv
//####################
// Line control definitions
// Sequencer states and buffer depth
//####################

package lineControlPkg;

	// Sequencer states
	// flushing: sweep after reset, both buffers to backdrop
	// waiting: idle between lines, lineStart accepted here
	// scanning: front buffer read out, one pixel per cycle
	typedef enum logic [1:0]
	{
		flushing,
		waiting,
		scanning
	} lineState;

	// Entries per line buffer
	localparam int lbDepth = 256;

endpackage

//--- source/bankCtrlIf.sv
//####################
// Buffer bank control bundle
// Buffer select, flush and scan strobes and
// the two column addresses into the bank
//####################

`timescale 1ns/1ps

interface bankCtrlIf
	import videoTypesPkg::*;
();

	// Buffer currently displayed
	logic frontSel;
	// Reset sweep in progress
	logic flushing;
	// Front buffer read this cycle
	logic scanRead;
	// Render column, back buffer
	lbAddr renderAddr;
	// Scan column, also the flush column
	lbAddr scanAddr;

	// Sequencer side
	modport seq (output frontSel, output flushing, output scanRead);

	// Column counters
	modport ctr (output renderAddr, output scanAddr);

	// Buffer bank takes everything
	modport bank (input frontSel, input flushing, input scanRead,
		input renderAddr, input scanAddr);

endinterface

//--- source/addressCounter.sv
//####################
// Line buffer column counter
// Loadable, steps by one, wraps at 256
//####################

`timescale 1ns/1ps

module addressCounter
	import videoTypesPkg::*;
(
	input logic CK1,
	input logic reset,
	input logic load,
	input lbAddr loadValue,
	input logic step,
	output lbAddr addr
);

	lbAddr count;
	lbAddr base;

	// Loaded column visible in the load cycle itself
	// so a write on the same strobe lands at loadValue
	assign base = load ? loadValue : count;
	assign addr = base;

	// Load and step together leave loadValue + 1
	always_ff @(posedge CK1)
	begin
		if (reset)
			count <= '0;
		else if (load || step)
			count <= base + lbAddr'(step);
	end

endmodule

//--- source/lineSequencer.sv
//####################
// Line sequencer
// Reset flush sweep, idle wait, scan-out timing
// Owns the front buffer select
//####################

`timescale 1ns/1ps

module lineSequencer
	import lineControlPkg::*;
#(
	parameter int activePixels = 256
)
(
	input logic CK1,
	input logic reset,
	input logic lineStart,
	bankCtrlIf.seq ctrl,
	output logic scanLoad,
	output logic scanStep,
	output logic ready
);

	localparam int timerBits = $clog2(lbDepth);

	lineState state;
	logic [timerBits-1:0] pixelTimer;
	logic lineAccept;
	logic timerDone;

	// Only honoured when idle and flushed
	assign ready = (state == waiting);
	assign lineAccept = ready && lineStart;

	// Sweep length or visible line length
	assign timerDone = (state == flushing) ?
		(pixelTimer == timerBits'(lbDepth - 1)) :
		(pixelTimer == timerBits'(activePixels - 1));

	always_ff @(posedge CK1)
	begin
		if (reset)
		begin
			state <= flushing;
			pixelTimer <= '0;
			ctrl.frontSel <= 1'b0;
		end
		else
		begin
			case (state)
				flushing:
				begin
					pixelTimer <= pixelTimer + 1'b1;
					if (timerDone)
						state <= waiting;
				end
				waiting:
				begin
					pixelTimer <= '0;
					// Swap buffers on accepted line start
					if (lineAccept)
					begin
						state <= scanning;
						ctrl.frontSel <= ~ctrl.frontSel;
					end
				end
				scanning:
				begin
					pixelTimer <= pixelTimer + 1'b1;
					// Extra lineStart here has no effect
					if (timerDone)
					begin
						state <= waiting;
						pixelTimer <= '0;
					end
				end
				default:
					state <= flushing;
			endcase
		end
	end

	assign ctrl.flushing = (state == flushing);
	assign ctrl.scanRead = (state == scanning);

	// Scan counter loads scanStart on line start
	assign scanLoad = lineAccept;
	// Counts from zero through the sweep, then across the line
	assign scanStep = (state != waiting);

endmodule

//--- source/lineBufferRam.sv
//####################
// Line buffer RAM
// 256 x 12, one write port, registered read
//####################

`timescale 1ns/1ps

module lineBufferRam
	import videoTypesPkg::*;
	import lineControlPkg::*;
(
	input logic CK1,
	input logic wrEn,
	input lbAddr wrAddr,
	input lbEntry wrData,
	input lbAddr rdAddr,
	output lbEntry rdData
);

	// Storage, contents set by the flush sweep
	lbEntry mem [lbDepth];

	always_ff @(posedge CK1)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	// Read port registered, old data on a same-address write
	always_ff @(posedge CK1)
	begin
		rdData <= mem[rdAddr];
	end

endmodule

//--- source/lineBufferBank.sv
//####################
// Line buffer bank
// Two ping-pong buffers, write steering for
// render, clear behind read and flush,
// front buffer read select
//####################

`timescale 1ns/1ps

module lineBufferBank
	import videoTypesPkg::*;
(
	input logic CK1,
	bankCtrlIf.bank ctrl,
	input logic sprWrite,
	input colorIndex sprColor,
	input spritePalette sprPalette,
	output lbEntry scanData,
	output logic scanValid
);

	lbEntry renderEntry;
	logic renderOpaque;
	// Read issued last cycle, its column and its buffer
	logic clearPending;
	lbAddr clearAddr;
	logic readSel;
	lbEntry rdData [2];

	// Palette above colour
	assign renderEntry = {sprPalette, sprColor};
	// Colour zero only moves the render column
	assign renderOpaque = sprWrite && (sprColor != '0);

	always_ff @(posedge CK1)
	begin
		clearPending <= ctrl.scanRead;
		clearAddr <= ctrl.scanAddr;
		readSel <= ctrl.frontSel;
	end

	for (genvar b = 0; b < 2; b++)
	begin : bufSlot
		logic wrEn;
		lbAddr wrAddr;
		lbEntry wrData;

		// Priority: flush, clear behind read, render to back buffer
		always_comb
		begin
			wrEn = 1'b0;
			wrAddr = ctrl.renderAddr;
			wrData = renderEntry;
			if (ctrl.flushing)
			begin
				wrEn = 1'b1;
				wrAddr = ctrl.scanAddr;
				wrData = backdropCode;
			end
			else if (clearPending && (readSel == 1'(b)))
			begin
				wrEn = 1'b1;
				wrAddr = clearAddr;
				wrData = backdropCode;
			end
			else if (renderOpaque && (ctrl.frontSel != 1'(b)))
				wrEn = 1'b1;
		end

		lineBufferRam ram (
			.CK1(CK1),
			.wrEn(wrEn),
			.wrAddr(wrAddr),
			.wrData(wrData),
			.rdAddr(ctrl.scanAddr),
			.rdData(rdData[b])
		);
	end

	// Data of the buffer that was front when read
	assign scanData = rdData[readSel];
	assign scanValid = clearPending;

endmodule

//--- source/pixelMixer.sv
//####################
// Pixel mixer
// Blank over fix over sprite, output register
//####################

`timescale 1ns/1ps

module pixelMixer
	import videoTypesPkg::*;
(
	input logic CK1,
	input logic reset,
	input logic scanValid,
	input lbEntry scanData,
	input colorIndex fixColor,
	input fixPalette fixPal,
	input logic blank,
	output paletteAddr pa,
	output logic pixelValid
);

	// Fix and blank, one stage behind to meet the RAM data
	colorIndex fixColorDly;
	fixPalette fixPalDly;
	logic blankDly;
	paletteAddr mixed;

	always_ff @(posedge CK1)
	begin
		fixColorDly <= fixColor;
		fixPalDly <= fixPal;
		blankDly <= blank;
	end

	// Blank forces zero
	// Opaque fix pixel next, top nibble zero
	// Else the line buffer word as is
	always_comb
	begin
		if (blankDly)
			mixed = '0;
		else if (fixColorDly != '0)
			mixed = {4'b0000, fixPalDly, fixColorDly};
		else
			mixed = scanData;
	end

	always_ff @(posedge CK1)
	begin
		if (reset)
		begin
			pa <= '0;
			pixelValid <= 1'b0;
		end
		else
		begin
			pa <= mixed;
			pixelValid <= scanValid;
		end
	end

endmodule

//--- source/lineBufferMixer.sv
//####################
// Sprite line buffer and palette mixer
// Ping-pong line buffers, scan-out with
// clear behind read, fix layer and blank mixing
//####################

`timescale 1ns/1ps

module lineBufferMixer
#(
	parameter int activePixels = 256
)
(
	input logic CK1,
	input logic reset,
	input logic lineStart,
	input logic [7:0] scanStart,
	input logic sprLoad,
	input logic [7:0] sprX,
	input logic sprWrite,
	input logic [3:0] sprColor,
	input logic [7:0] sprPalette,
	input logic [3:0] fixColor,
	input logic [3:0] fixPalette,
	input logic blank,
	output logic [11:0] pa,
	output logic pixelValid,
	output logic ready
);

	logic scanLoad;
	logic scanStep;
	logic [11:0] scanData;
	logic scanValid;

	bankCtrlIf bankCtrl ();

	lineSequencer #(.activePixels(activePixels)) sequencer (
		.CK1(CK1), .reset(reset), .lineStart(lineStart), .ctrl(bankCtrl.seq),
		.scanLoad(scanLoad), .scanStep(scanStep), .ready(ready)
	);

	// Render column, follows the sprite strip
	addressCounter renderCounter (
		.CK1(CK1), .reset(reset), .load(sprLoad), .loadValue(sprX),
		.step(sprWrite), .addr(bankCtrl.renderAddr)
	);

	// Scan column, also sweeps the flush
	addressCounter scanCounter (
		.CK1(CK1), .reset(reset), .load(scanLoad), .loadValue(scanStart),
		.step(scanStep), .addr(bankCtrl.scanAddr)
	);

	lineBufferBank bank (
		.CK1(CK1), .ctrl(bankCtrl.bank), .sprWrite(sprWrite), .sprColor(sprColor),
		.sprPalette(sprPalette), .scanData(scanData), .scanValid(scanValid)
	);

	pixelMixer mixer (
		.CK1(CK1), .reset(reset), .scanValid(scanValid), .scanData(scanData),
		.fixColor(fixColor), .fixPal(fixPalette), .blank(blank),
		.pa(pa), .pixelValid(pixelValid)
	);

endmodule

//--- verif/lineBufferMixerTb.sv
//####################
// Line buffer mixer testbench
// Table of lines, sprite strips rendered ahead,
// scan-out checked against a model of both buffers
//####################

`timescale 1ns/1ps

module lineBufferMixerTb
	import videoTypesPkg::*;
();

	localparam int activePx = 24;
	localparam paletteAddr backdropAddr = 12'hfff;
	localparam int lineCount = 7;

	// One line with two strips, scan window, fix span and blank span
	// extraStart gives the step of a second lineStart or zero for none
	typedef struct packed {
		lbAddr aStart;
		logic [7:0] aLen;
		spritePalette aPal;
		lbAddr bStart;
		logic [7:0] bLen;
		spritePalette bPal;
		lbAddr scanFrom;
		logic [4:0] fixFrom;
		logic [4:0] fixTo;
		fixPalette fixPal;
		colorIndex fixCol;
		logic [4:0] blankFrom;
		logic [4:0] blankTo;
		logic [4:0] extraStart;
	} lineRow;

	logic CK1;
	logic reset;
	logic lineStart;
	lbAddr scanStart;
	logic sprLoad;
	lbAddr sprX;
	logic sprWrite;
	colorIndex sprColor;
	spritePalette sprPalette;
	colorIndex fixColor;
	fixPalette fixPal;
	logic blank;
	paletteAddr pa;
	logic pixelValid;
	logic ready;

	lineRow rows [lineCount];
	// Both buffers as the DUT should hold them
	paletteAddr model [2][256];
	logic modelFront;
	integer seed;

	lineBufferMixer #(.activePixels(activePx)) dut0 (
		.CK1(CK1), .reset(reset), .lineStart(lineStart), .scanStart(scanStart),
		.sprLoad(sprLoad), .sprX(sprX), .sprWrite(sprWrite), .sprColor(sprColor),
		.sprPalette(sprPalette), .fixColor(fixColor), .fixPalette(fixPal),
		.blank(blank), .pa(pa), .pixelValid(pixelValid), .ready(ready)
	);

	initial
	begin
		CK1 = 1'b0;
		forever #4 CK1 = ~CK1;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic checkAddr(input string name, input paletteAddr expected,
		input paletteAddr actual);
		if (actual !== expected)
			abortRun($sformatf("error %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("error %s expected %b actual %b", name, expected, actual));
	endtask

	task automatic checkCycles(input string name, input int expected, input int actual);
		if (actual != expected)
			abortRun($sformatf("error %s expected %0d actual %0d", name, expected, actual));
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic nextDrivePoint();
		@(posedge CK1);
		#1;
	endtask

	// One strip into the back buffer with every fifth colour forced transparent
	task automatic renderStrip(input lbAddr start, input logic [7:0] len,
		input spritePalette pal);
		colorIndex c;
		lbAddr col;
		col = start;
		for (int j = 0; j < int'(len); j++)
		begin
			c = colorIndex'($random(seed));
			if (j % 5 == 3)
				c = '0;
			sprLoad = (j == 0);
			sprX = start;
			sprWrite = 1'b1;
			sprColor = c;
			sprPalette = pal;
			if (c != '0)
				model[~modelFront][col] = {pal, c};
			col = col + 8'd1;
			nextDrivePoint();
		end
		sprLoad = 1'b0;
		sprWrite = 1'b0;
	endtask

	task automatic waitReady(input int r);
		int n;
		n = 0;
		while (ready !== 1'b1)
		begin
			nextDrivePoint();
			n++;
			if (n > 100)
				abortRun($sformatf("timed out waiting for ready before line %0d", r));
		end
	endtask

	// Render, start the line, then follow all 24 pixels
	task automatic runLine(input int r);
		lineRow row;
		int k;
		int got;
		int px;
		lbAddr col;
		paletteAddr expected;
		string name;
		row = rows[r];
		renderStrip(row.aStart, row.aLen, row.aPal);
		renderStrip(row.bStart, row.bLen, row.bPal);
		waitReady(r);
		scanStart = row.scanFrom;
		fixPal = row.fixPal;
		lineStart = 1'b1;
		// Swap on the accepted line start
		modelFront = ~modelFront;
		k = 0;
		got = 0;
		while (got < activePx || k < activePx + 6)
		begin
			nextDrivePoint();
			k++;
			if (k > activePx + 40)
				abortRun($sformatf("timed out waiting for pixelValid on line %0d", r));
			// Second strobe mid-line must be ignored
			lineStart = (k == int'(row.extraStart));
			// Fix and blank for pixel k-1 as sampled on the next edge
			px = k - 1;
			fixColor = (px < activePx && px >= int'(row.fixFrom) && px < int'(row.fixTo)) ?
				row.fixCol : '0;
			blank = (px < activePx && px >= int'(row.blankFrom) && px < int'(row.blankTo));
			name = $sformatf("line %0d step %0d pixelValid", r, k);
			checkFlag(name, (k >= 3 && k < 3 + activePx), pixelValid);
			if (pixelValid === 1'b1)
			begin
				name = $sformatf("line %0d pixel %0d", r, got);
				col = row.scanFrom + lbAddr'(got);
				if (got >= int'(row.blankFrom) && got < int'(row.blankTo))
					expected = '0;
				else if (got >= int'(row.fixFrom) && got < int'(row.fixTo) && row.fixCol != '0)
					expected = {4'h0, row.fixPal, row.fixCol};
				else
					expected = model[modelFront][col];
				// Cleared behind the read even under blank or fix
				model[modelFront][col] = backdropAddr;
				checkAddr(name, expected, pa);
				got++;
			end
		end
	endtask

	initial
	begin
		int steps;
		reset = 1'b1;
		lineStart = 1'b0;
		scanStart = '0;
		sprLoad = 1'b0;
		sprX = '0;
		sprWrite = 1'b0;
		sprColor = '0;
		sprPalette = '0;
		fixColor = '0;
		fixPal = '0;
		blank = 1'b0;
		seed = 32'hb641_73eb;
		modelFront = 1'b0;
		for (int b = 0; b < 2; b++)
			for (int a = 0; a < 256; a++)
				model[b][a] = backdropAddr;

		// Empty line, overlapping strips, wrap, rescan with stale tail
		rows[0] = '{8'd0, 8'd0, 8'h00, 8'd0, 8'd0, 8'h00, 8'd0,
			5'd0, 5'd0, 4'h3, 4'h0, 5'd0, 5'd0, 5'd0};
		rows[1] = '{8'd10, 8'd12, 8'h21, 8'd20, 8'd14, 8'h5a, 8'd4,
			5'd0, 5'd0, 4'h0, 4'h0, 5'd0, 5'd0, 5'd0};
		rows[2] = '{8'd250, 8'd14, 8'h33, 8'd0, 8'd0, 8'h00, 8'd244,
			5'd0, 5'd0, 4'h0, 4'h0, 5'd0, 5'd0, 5'd0};
		rows[3] = '{8'd0, 8'd0, 8'h00, 8'd0, 8'd0, 8'h00, 8'd16,
			5'd0, 5'd0, 4'h0, 4'h0, 5'd0, 5'd0, 5'd0};
		// Fix span with blank over part of it, then a mid-line strobe
		rows[4] = '{8'd100, 8'd24, 8'h7c, 8'd112, 8'd6, 8'hc4, 8'd96,
			5'd8, 5'd16, 4'h9, 4'h6, 5'd12, 5'd20, 5'd0};
		rows[5] = '{8'd128, 8'd10, 8'h4e, 8'd0, 8'd0, 8'h00, 8'd120,
			5'd0, 5'd4, 4'ha, 4'h1, 5'd22, 5'd24, 5'd10};
		rows[6] = '{8'd0, 8'd0, 8'h00, 8'd0, 8'd0, 8'h00, 8'd110,
			5'd0, 5'd0, 4'h0, 4'h0, 5'd0, 5'd0, 5'd0};

		repeat (10) @(posedge CK1);
		#1;
		reset = 1'b0;
		checkFlag("ready after reset release", 1'b0, ready);

		// Early lineStart during the flush sweep must not start a line
		steps = 0;
		while (ready !== 1'b1)
		begin
			nextDrivePoint();
			steps++;
			lineStart = (steps == 50);
			checkFlag($sformatf("pixelValid during flush step %0d", steps), 1'b0, pixelValid);
			if (steps > 300)
				abortRun("timed out waiting for ready after reset");
		end
		lineStart = 1'b0;
		checkCycles("cycles from reset to ready", 256, steps);

		for (int r = 0; r < lineCount; r++)
			runLine(r);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- lineBufferMixer.f
source/videoTypesPkg.sv
source/lineControlPkg.sv
source/bankCtrlIf.sv
source/addressCounter.sv
source/lineSequencer.sv
source/lineBufferRam.sv
source/lineBufferBank.sv
source/pixelMixer.sv
source/lineBufferMixer.sv
verif/lineBufferMixerTb.sv

//--- run.sh
#!/bin/sh
# Build and run the line buffer mixer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module lineBufferMixerTb \
	-f lineBufferMixer.f \
	-o simv

# The simulation exits nonzero on a failed check, the log decides
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
